// File: design/pma_pkg.sv
/*
  PMA checker shared definitions
  sizes, memory/atomic/address-mode enums, transfer size
  and the packed per-entry attribute struct
*/
`default_nettype none

package pma_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  // number of region entries
  localparam int PMA_CNT   = 8;
  // region address register width, holds adr[PLEN-1:2]
  localparam int XLEN      = 32;
  // physical address width
  localparam int PLEN      = 34;
  // entry index width
  localparam int PMA_IDX_W = 3;

  ////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////

  // kind of memory behind a region
  typedef enum logic [1:0] {
    MEM_TYPE_EMPTY = 2'd0,
    MEM_TYPE_MAIN  = 2'd1,
    MEM_TYPE_IO    = 2'd2,
    MEM_TYPE_TCM   = 2'd3
  } mem_type_e;

  // atomic support level, stored only
  typedef enum logic [1:0] {
    AMO_TYPE_NONE    = 2'd0,
    AMO_TYPE_SWAP    = 2'd1,
    AMO_TYPE_LOGICAL = 2'd2,
    AMO_TYPE_ARITH   = 2'd3
  } amo_type_e;

  // region matching mode, same encoding as pmpcfg.A
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } addr_mode_e;

  // transfer size of one access
  typedef enum logic [2:0] {
    BYTE  = 3'd0,
    HWORD = 3'd1,
    WORD  = 3'd2,
    DWORD = 3'd3
  } xfer_size_e;

  ////////////////////////////////////////////////////////////
  // per-entry attributes, 14 bits
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    mem_type_e  mem_type;
    amo_type_e  amo_type;
    addr_mode_e a;
    logic       r;   // readable
    logic       w;   // writable
    logic       x;   // executable
    logic       c;   // cacheable
    logic       cc;  // cache coherent
    logic       ri;  // read idempotent
    logic       wi;  // write idempotent
    logic       m;   // misaligned allowed
  } pmacfg_t;

endpackage

`default_nettype wire

// File: design/pma_access_if.sv
/*
  PMA access request bundle
  one physical access as seen by the range matcher and the checker
*/
`timescale 1ns/1ps
`default_nettype none

interface pma_access_if
  import pma_pkg::*;
();

  // access presented this cycle
  logic             req;
  // instruction fetch
  logic             instruction;
  // write access
  logic             we;
  // transfer size
  xfer_size_e       size;
  // physical address, after translation
  logic [PLEN-1:0]  adr;
  // access not naturally aligned
  logic             misaligned;

  // range matcher only needs the byte span
  modport match (
    input adr,
    input size
  );

  // checker needs the kind of access
  modport check (
    input req,
    input instruction,
    input we,
    input misaligned
  );

endinterface

`default_nettype wire

// File: design/pma_cfg_regs.sv
/*
  PMA entry register bank
  eight software-written entries of attributes plus region address,
  attributes are cleaned on write so the access path sees legal values
*/
`timescale 1ns/1ps
`default_nettype none

module pma_cfg_regs
  import pma_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            reset_i,

  // write port
  input  wire logic                 cfg_we_i,
  input  wire logic [PMA_IDX_W-1:0] cfg_idx_i,
  input  wire pmacfg_t              cfg_data_i,
  input  wire logic [XLEN-1:0]      cfg_adr_i,

  // stored entries
  output pmacfg_t              pma_cfg_o [PMA_CNT],
  output logic [XLEN-1:0]      pma_adr_o [PMA_CNT]
);

  ////////////////////////////////////////////////////////////
  // attribute cleanup
  ////////////////////////////////////////////////////////////

  function automatic pmacfg_t clean_cfg(input pmacfg_t raw);
    pmacfg_t cln;

    // m and a pass through untouched
    cln = raw;

    // empty region, treat as dead IO
    if (raw.mem_type == MEM_TYPE_EMPTY)
    begin
      cln.mem_type = MEM_TYPE_IO;
      cln.amo_type = AMO_TYPE_NONE;
      cln.r        = 1'b0;
      cln.w        = 1'b0;
      cln.x        = 1'b0;
    end

    // only main memory may be cached
    cln.c  = (raw.mem_type == MEM_TYPE_MAIN) ? raw.c : 1'b0;
    // coherency means nothing without caching
    cln.cc = raw.cc & cln.c;

    // idempotency only programmable for IO
    if (raw.mem_type != MEM_TYPE_IO)
    begin
      cln.ri = 1'b1;
      cln.wi = 1'b1;
    end

    return cln;
  endfunction

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  pmacfg_t         cfg_q [PMA_CNT];
  logic [XLEN-1:0] adr_q [PMA_CNT];

  // cleaned write data
  pmacfg_t         cfg_wr;

  assign cfg_wr = clean_cfg(cfg_data_i);

  // all entries come up OFF at address zero
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int n = 0; n < PMA_CNT; n++)
      begin
        cfg_q[n] <= '0;
        adr_q[n] <= '0;
      end
    end
    else if (cfg_we_i)
    begin
      cfg_q[cfg_idx_i] <= cfg_wr;
      adr_q[cfg_idx_i] <= cfg_adr_i;
    end
  end

  // new values visible to the matcher next cycle
  assign pma_cfg_o = cfg_q;
  assign pma_adr_o = adr_q;

endmodule

`default_nettype wire

// File: design/pma_region_match.sv
/*
  PMA region matcher
  computes each entry's bounds on word granularity and flags
  the entries that hold every byte of the current access
*/
`timescale 1ns/1ps
`default_nettype none

module pma_region_match
  import pma_pkg::*;
(
  input  pmacfg_t              pma_cfg_i [PMA_CNT],
  input  wire logic [XLEN-1:0] pma_adr_i [PMA_CNT],

  pma_access_if.match          acc,

  output logic [PMA_CNT-1:0]   match_all_o
);

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // bytes moved by one transfer
  function automatic logic [3:0] size2bytes(input xfer_size_e size);
    logic [3:0] nb;

    case (size)
      BYTE    : nb = 4'd1;
      HWORD   : nb = 4'd2;
      WORD    : nb = 4'd4;
      DWORD   : nb = 4'd8;
      default : nb = 4'd1;
    endcase
    return nb;
  endfunction

  // region alignment mask for NA4/NAPOT
  // NA4 keeps every word bit, NAPOT drops one bit plus one per trailing one
  function automatic logic [PLEN-1:2] napot_mask(input logic na4,
                                                 input logic [PLEN-1:2] pmaddr);
    logic [PLEN-1:2] mask;
    logic            run;

    mask = '1;
    run  = 1'b1;
    if (!na4)
    begin
      // smallest napot region is 8 bytes
      mask = mask << 1;
      for (int k = 2; k < PLEN; k++)
      begin
        run = run & pmaddr[k];
        if (run)
          mask = mask << 1;
      end
    end
    return mask;
  endfunction

  ////////////////////////////////////////////////////////////
  // access span
  ////////////////////////////////////////////////////////////

  logic [PLEN-1:0] access_lb;
  logic [PLEN-1:0] access_ub;

  assign access_lb = acc.adr;
  // last byte touched
  assign access_ub = acc.adr + PLEN'(size2bytes(acc.size)) - PLEN'(1);

  ////////////////////////////////////////////////////////////
  // region bounds, lb inclusive, ub exclusive
  ////////////////////////////////////////////////////////////

  logic [PLEN-1:2] pma_lb [PMA_CNT];
  logic [PLEN-1:2] pma_ub [PMA_CNT];
  logic [PLEN-1:2] mask   [PMA_CNT];

  // upper bounds depend on the own entry only
  always_comb
  begin
    for (int i = 0; i < PMA_CNT; i++)
    begin
      mask[i] = napot_mask(pma_cfg_i[i].a == NA4, pma_adr_i[i]);
      case (pma_cfg_i[i].a)
        TOR     : pma_ub[i] = pma_adr_i[i];
        NA4,
        NAPOT   : pma_ub[i] = (pma_adr_i[i] + ((~mask[i]) + 1'b1)) & mask[i];
        default : pma_ub[i] = '0;
      endcase
    end
  end

  // lower bounds, TOR chains off the previous entry
  always_comb
  begin
    for (int i = 0; i < PMA_CNT; i++)
    begin
      case (pma_cfg_i[i].a)
        TOR :
        begin
          // entry 0 starts at address zero
          if (i == 0)
            pma_lb[i] = '0;
          // TOR after NA4/NAPOT/OFF starts at its upper bound
          else if (pma_cfg_i[i-1].a != TOR)
            pma_lb[i] = pma_ub[i-1];
          else
            pma_lb[i] = pma_adr_i[i-1];
        end
        NA4,
        NAPOT   : pma_lb[i] = pma_adr_i[i] & mask[i];
        default : pma_lb[i] = '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // all-bytes match
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < PMA_CNT; i++)
    begin
      match_all_o[i] = (pma_cfg_i[i].a != OFF) &&
                       (access_lb[PLEN-1:2] >= pma_lb[i]) &&
                       (access_ub[PLEN-1:2] <  pma_ub[i]);
    end
  end

endmodule

`default_nettype wire

// File: design/pma_checker.sv
/*
  PMA checker
  registers the priority match and access kind, then forms
  access exception, misaligned and cacheable from the selected entry
*/
`timescale 1ns/1ps
`default_nettype none

module pma_checker
  import pma_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              stall_i,

  input  pmacfg_t                pma_cfg_i [PMA_CNT],
  input  wire logic [PMA_CNT-1:0] match_all_i,

  pma_access_if.check            acc,

  output logic                   exception_o,
  output logic                   misaligned_o,
  output logic                   cacheable_o
);

  ////////////////////////////////////////////////////////////
  // priority pick
  ////////////////////////////////////////////////////////////

  // lowest numbered set bit wins, 0 when none set
  function automatic logic [PMA_IDX_W-1:0] lowest_set(input logic [PMA_CNT-1:0] m);
    logic [PMA_IDX_W-1:0] idx;

    idx = '0;
    for (int n = PMA_CNT-1; n >= 0; n--)
    begin
      if (m[n])
        idx = PMA_IDX_W'(n);
    end
    return idx;
  endfunction

  ////////////////////////////////////////////////////////////
  // pipeline register
  ////////////////////////////////////////////////////////////

  logic                 req_q;
  logic [PMA_IDX_W-1:0] idx_q;
  logic                 hit_q;
  logic                 we_q;
  logic                 instr_q;
  logic                 mis_q;

  // request valid, the only state needing reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      req_q <= 1'b0;
    else if (!stall_i)
      req_q <= acc.req;
  end

  // payload, held during stall
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      idx_q   <= lowest_set(match_all_i);
      hit_q   <= |match_all_i;
      we_q    <= acc.we;
      instr_q <= acc.instruction;
      mis_q   <= acc.misaligned;
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  pmacfg_t sel_cfg;
  logic    perm_fault;

  // current attributes of the registered entry
  assign sel_cfg = pma_cfg_i[idx_q];

  // fetch needs x, store needs w, load needs r
  assign perm_fault = ( instr_q          & ~sel_cfg.x) |
                      ( we_q             & ~sel_cfg.w) |
                      (~we_q & ~instr_q  & ~sel_cfg.r);

  // no region at all also faults
  assign exception_o  = req_q & (~hit_q | perm_fault);

  assign misaligned_o = req_q & mis_q & ~sel_cfg.m;

  // c already implies main memory after cleanup
  assign cacheable_o  = req_q & sel_cfg.c;

endmodule

`default_nettype wire

// File: design/pma_unit_top.sv
/*
  PMA unit top level
  register bank, region matcher and checker behind plain ports
*/
`timescale 1ns/1ps
`default_nettype none

module pma_unit_top
  import pma_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  input  wire logic                 stall_i,

  // entry write port
  input  wire logic                 cfg_we_i,
  input  wire logic [PMA_IDX_W-1:0] cfg_idx_i,
  input  wire pmacfg_t              cfg_data_i,
  input  wire logic [XLEN-1:0]      cfg_adr_i,

  // access
  input  wire logic                 req_i,
  input  wire logic                 instruction_i,
  input  wire logic                 we_i,
  input  wire xfer_size_e           size_i,
  input  wire logic [PLEN-1:0]      adr_i,
  input  wire logic                 misaligned_i,

  // result, one cycle after the access
  output logic                      exception_o,
  output logic                      misaligned_o,
  output logic                      cacheable_o
);

  pmacfg_t              pma_cfg [PMA_CNT];
  logic [XLEN-1:0]      pma_adr [PMA_CNT];
  logic [PMA_CNT-1:0]   match_all;

  pma_access_if u_acc ();

  // access bundle from the top ports
  assign u_acc.req         = req_i;
  assign u_acc.instruction = instruction_i;
  assign u_acc.we          = we_i;
  assign u_acc.size        = size_i;
  assign u_acc.adr         = adr_i;
  assign u_acc.misaligned  = misaligned_i;

  pma_cfg_regs u_pma_cfg_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_idx_i  (cfg_idx_i),
    .cfg_data_i (cfg_data_i),
    .cfg_adr_i  (cfg_adr_i),
    .pma_cfg_o  (pma_cfg),
    .pma_adr_o  (pma_adr)
  );

  pma_region_match u_pma_region_match (
    .pma_cfg_i   (pma_cfg),
    .pma_adr_i   (pma_adr),
    .acc         (u_acc),
    .match_all_o (match_all)
  );

  pma_checker u_pma_checker (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .stall_i      (stall_i),
    .pma_cfg_i    (pma_cfg),
    .match_all_i  (match_all),
    .acc          (u_acc),
    .exception_o  (exception_o),
    .misaligned_o (misaligned_o),
    .cacheable_o  (cacheable_o)
  );

endmodule

`default_nettype wire

// File: tb/pma_unit_tb.sv
/*
  PMA unit testbench
  programs a fixed region map, then applies a table of accesses
  one per cycle and checks exception, misaligned and cacheable
*/
`timescale 1ns/1ps
`default_nettype none

module pma_unit_tb
  import pma_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DLY    = 1;
  localparam int RESET_CYCLES = 4;
  localparam int N_WRITES     = 6;
  localparam int MARGIN       = 16;

  ////////////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////////////

  logic                 clk;
  logic                 reset;
  logic                 stall;
  logic                 cfg_we;
  logic [PMA_IDX_W-1:0] cfg_idx;
  pmacfg_t              cfg_data;
  logic [XLEN-1:0]      cfg_adr;
  logic                 req;
  logic                 instr;
  logic                 we;
  xfer_size_e           size;
  logic [PLEN-1:0]      adr;
  logic                 mis;
  logic                 exception_o;
  logic                 misaligned_o;
  logic                 cacheable_o;

  pma_unit_top u_pma_unit_top (
    .clk_i         (clk),
    .reset_i       (reset),
    .stall_i       (stall),
    .cfg_we_i      (cfg_we),
    .cfg_idx_i     (cfg_idx),
    .cfg_data_i    (cfg_data),
    .cfg_adr_i     (cfg_adr),
    .req_i         (req),
    .instruction_i (instr),
    .we_i          (we),
    .size_i        (size),
    .adr_i         (adr),
    .misaligned_i  (mis),
    .exception_o   (exception_o),
    .misaligned_o  (misaligned_o),
    .cacheable_o   (cacheable_o)
  );

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  // one access plus its expected result
  typedef struct packed {
    logic            req;
    logic            instr;
    logic            we;
    xfer_size_e      size;
    logic [PLEN-1:0] adr;
    logic            mis;
    logic            stall;
    logic            exp_exc;
    logic            exp_mis;
    logic            exp_cache;
  } row_t;

  row_t  rows [$];
  string names [$];

  int    pass_cnt;
  int    fail_cnt;
  int    cycles;
  int    cycle_limit;
  int    second_run;

  task automatic add_row(input string nm, input logic rq, input logic ins, input logic wr,
                         input xfer_size_e sz, input logic [PLEN-1:0] a, input logic ms,
                         input logic st, input logic e_exc, input logic e_mis,
                         input logic e_cache);
    row_t r;

    r.req       = rq;
    r.instr     = ins;
    r.we        = wr;
    r.size      = sz;
    r.adr       = a;
    r.mis       = ms;
    r.stall     = st;
    r.exp_exc   = e_exc;
    r.exp_mis   = e_mis;
    r.exp_cache = e_cache;
    rows.push_back(r);
    names.push_back(nm);
  endtask

  // columns: name, req, fetch, write, size, adr, misaligned, stall, exc, mis, cache
  task automatic build_table();
    add_row("idle_no_req",      0, 0, 0, WORD,  34'h0,     0, 0,  0, 0, 0);
    add_row("e1_read",          1, 0, 0, WORD,  34'h1000,  0, 0,  0, 0, 1);
    add_row("e1_write",         1, 0, 1, WORD,  34'h1004,  0, 0,  0, 0, 1);
    add_row("e1_fetch",         1, 1, 0, WORD,  34'h1008,  0, 0,  0, 0, 1);
    add_row("e1_dword_top",     1, 0, 0, DWORD, 34'h1ff8,  0, 0,  0, 0, 1);
    add_row("e1_misaligned",    1, 0, 0, WORD,  34'h1002,  1, 0,  0, 0, 1);
    // held result from e1_misaligned
    add_row("stall_fault_in",   1, 0, 1, WORD,  34'h8000,  0, 1,  0, 0, 1);
    add_row("stall_idle_in",    0, 0, 0, BYTE,  34'h0,     0, 1,  0, 0, 1);
    add_row("e0_read",          1, 0, 0, WORD,  34'h100,   0, 0,  0, 0, 0);
    add_row("e2_read",          1, 0, 0, WORD,  34'h3000,  0, 0,  0, 0, 0);
    add_row("e2_misaligned",    1, 0, 0, WORD,  34'h2002,  1, 0,  0, 1, 0);
    add_row("e0_write",         1, 0, 1, WORD,  34'h100,   0, 0,  1, 0, 0);
    add_row("e2_fetch",         1, 1, 0, WORD,  34'h2100,  0, 0,  1, 0, 0);
    add_row("e3_read",          1, 0, 0, WORD,  34'h8000,  0, 0,  1, 0, 0);
    add_row("e3_write",         1, 0, 1, WORD,  34'h8010,  0, 0,  1, 0, 0);
    add_row("e3_fetch",         1, 1, 0, WORD,  34'h8020,  0, 0,  1, 0, 0);
    // overlap with entry 4, lower index wins
    add_row("prio_e2_write",    1, 0, 1, WORD,  34'h2000,  0, 0,  0, 0, 0);
    add_row("e4_write",         1, 0, 1, WORD,  34'h5000,  0, 0,  1, 0, 0);
    add_row("e4_read",          1, 0, 0, WORD,  34'h5000,  0, 0,  0, 0, 0);
    // spans past the NA4 word, falls to entry 4
    add_row("straddle_read",    1, 0, 0, WORD,  34'h102,   1, 0,  0, 1, 0);
    add_row("straddle_write",   1, 0, 1, WORD,  34'h102,   0, 0,  1, 0, 0);
    add_row("no_match_high",    1, 0, 0, WORD,  34'h20000, 0, 0,  1, 0, 0);
    add_row("no_match_e4_end",  1, 0, 0, DWORD, 34'hfffc,  0, 0,  1, 0, 0);
    add_row("idle_after",       0, 1, 1, WORD,  34'h1000,  1, 0,  0, 0, 0);
    second_run = rows.size();
    // entry 1 rewritten without w
    add_row("e1_write_no_w",    1, 0, 1, WORD,  34'h1010,  0, 0,  1, 0, 1);
    add_row("e1_read_rewrite",  1, 0, 0, WORD,  34'h1010,  0, 0,  0, 0, 1);
    add_row("e1_fetch_rewrite", 1, 1, 0, WORD,  34'h1014,  0, 0,  0, 0, 1);
    add_row("idle_end",         0, 0, 0, WORD,  34'h0,     0, 0,  0, 0, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic pmacfg_t build_cfg(input mem_type_e mt, input addr_mode_e mode,
                                        input logic r, input logic w, input logic x,
                                        input logic c, input logic m);
    pmacfg_t cfg;

    cfg          = '0;
    cfg.mem_type = mt;
    cfg.amo_type = AMO_TYPE_NONE;
    cfg.a        = mode;
    cfg.r        = r;
    cfg.w        = w;
    cfg.x        = x;
    cfg.c        = c;
    cfg.m        = m;
    return cfg;
  endfunction

  // entered and left just after a rising edge
  task automatic write_entry(input int idx, input pmacfg_t cfg, input logic [XLEN-1:0] a);
    cfg_we   = 1'b1;
    cfg_idx  = PMA_IDX_W'(idx);
    cfg_data = cfg;
    cfg_adr  = a;
    @(posedge clk);
    #DRIVE_DLY;
    cfg_we   = 1'b0;
  endtask

  task automatic check_row(input string nm, input logic e_exc, input logic e_mis,
                           input logic e_cache);
    logic [2:0] exp_v;
    logic [2:0] act_v;
    logic       ok;

    exp_v = {e_exc, e_mis, e_cache};
    act_v = {exception_o, misaligned_o, cacheable_o};
    ok    = 1'b1;
    assert (act_v === exp_v)
    else
    begin
      ok = 1'b0;
      $display("[ERROR] %s expected exc/mis/cache=%b actual=%b", nm, exp_v, act_v);
    end
    if (ok)
    begin
      pass_cnt++;
      $display("[ok] %s exc/mis/cache=%b", nm, act_v);
    end
    else
      fail_cnt++;
  endtask

  // one row per cycle, result checked after the next edge
  task automatic run_rows(input int first, input int last);
    row_t r;

    for (int k = first; k < last; k++)
    begin
      r     = rows[k];
      req   = r.req;
      instr = r.instr;
      we    = r.we;
      size  = r.size;
      adr   = r.adr;
      mis   = r.mis;
      stall = r.stall;
      @(posedge clk);
      #DRIVE_DLY;
      check_row(names[k], r.exp_exc, r.exp_mis, r.exp_cache);
    end
    req   = 1'b0;
    stall = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    reset    = 1'b1;
    stall    = 1'b0;
    cfg_we   = 1'b0;
    cfg_idx  = '0;
    cfg_data = '0;
    cfg_adr  = '0;
    req      = 1'b0;
    instr    = 1'b0;
    we       = 1'b0;
    size     = WORD;
    adr      = '0;
    mis      = 1'b0;
    pass_cnt = 0;
    fail_cnt = 0;
    cycles   = 0;

    build_table();
    cycle_limit = RESET_CYCLES + N_WRITES + rows.size() + MARGIN;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;
    check_row("reset_idle", 1'b0, 1'b0, 1'b0);

    // region map, pmaddr holds adr[33:2]
    // c asked for on IO and empty entries, cleanup must drop it
    write_entry(0, build_cfg(MEM_TYPE_IO,    NA4,   1, 0, 0, 1, 0), 32'h0000_0040);
    write_entry(1, build_cfg(MEM_TYPE_MAIN,  NAPOT, 1, 1, 1, 1, 1), 32'h0000_05ff);
    write_entry(2, build_cfg(MEM_TYPE_IO,    TOR,   1, 1, 0, 1, 0), 32'h0000_1000);
    write_entry(3, build_cfg(MEM_TYPE_EMPTY, NAPOT, 1, 1, 1, 1, 0), 32'h0000_21ff);
    write_entry(4, build_cfg(MEM_TYPE_MAIN,  NAPOT, 1, 0, 0, 0, 0), 32'h0000_1fff);

    run_rows(0, second_run);

    // entry 1 loses write permission
    write_entry(1, build_cfg(MEM_TYPE_MAIN,  NAPOT, 1, 0, 1, 1, 1), 32'h0000_05ff);

    run_rows(second_run, rows.size());

    $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
design/pma_pkg.sv
design/pma_access_if.sv
design/pma_cfg_regs.sv
design/pma_region_match.sv
design/pma_checker.sv
design/pma_unit_top.sv
tb/pma_unit_tb.sv

// File: Makefile
# Verilator build and run for the PMA unit testbench

TOP := pma_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
